// ==== mem_msg_pkg.sv ====
// memory port message fields shared by every stage of the port
// one word is one data_t, byte addresses must be word aligned
package mem_msg_pkg;

	//==========================================================
	// message type
	//==========================================================

	// request and response carry the same kind field
	typedef logic msg_type_t;

	// read request, or read data coming back
	localparam msg_type_t mt_read = 1'b0;

	// write request, or write acknowledgment coming back
	localparam msg_type_t mt_write = 1'b1;

	//==========================================================
	// payload fields
	//==========================================================

	// requester tag, returned untouched with the response
	// lets the core match responses to outstanding requests
	typedef logic [7:0] opaque_t;

	// byte address on the request port
	// between stages the same width carries the word index
	typedef logic [31:0] addr_t;

	// one memory word
	// write data on requests, read data on responses
	typedef logic [31:0] data_t;

endpackage

// ==== sec_pkg.sv ====
// security levels for the memory port, higher value means more privileged
// only two levels exist, so the level compare is a single bit compare
package sec_pkg;

	//==========================================================
	// security level
	//==========================================================

	// level of a memory region, and of the processor
	typedef logic sec_level_t;

	// region anyone may read
	localparam sec_level_t sec_public = 1'b0;

	// region readable only by a secure processor
	localparam sec_level_t sec_secure = 1'b1;

endpackage

// ==== mem_req_decode.sv ====
// request stage, one pipeline register, full rate when downstream drains
// addresses must be word aligned, anything else is flagged as an error
`timescale 1ns/1ps

module mem_req_decode #(
	parameter int unsigned mem_words   = 64,
	parameter int unsigned secure_base = 32
) (
	input  logic                    clk,
	input  logic                    rst_n,

	// request from the processor
	input  logic                    req_val,
	output logic                    req_rdy,
	input  mem_msg_pkg::msg_type_t  req_type,
	input  mem_msg_pkg::opaque_t    req_opaque,
	input  mem_msg_pkg::addr_t      req_addr,
	input  mem_msg_pkg::data_t      req_data,

	// decoded request to the bank
	output logic                    dec_val,
	input  logic                    dec_rdy,
	output mem_msg_pkg::msg_type_t  dec_type,
	output mem_msg_pkg::opaque_t    dec_opaque,
	output mem_msg_pkg::addr_t      dec_index,
	output mem_msg_pkg::data_t      dec_data,
	output logic                    dec_err,
	output sec_pkg::sec_level_t     dec_sec_level
);

	import mem_msg_pkg::*;
	import sec_pkg::*;

	// byte offset bits inside one word
	localparam int unsigned word_shift = $clog2($bits(data_t) / 8);

	addr_t      req_index;
	logic       req_misaligned;
	logic       req_out_of_range;
	sec_level_t req_level;
	logic       req_fire;

	//==========================================================
	// field split and checks
	//==========================================================

	// word index drops the byte offset
	assign req_index = req_addr >> word_shift;

	// any nonzero low bit means a partial or straddling word
	assign req_misaligned = |req_addr[word_shift-1:0];

	// index past the end of the bank
	assign req_out_of_range = (req_index >= addr_t'(mem_words));

	// region level comes from the index alone
	// a misaligned address still lands in a region
	assign req_level = (req_index >= addr_t'(secure_base)) ? sec_secure : sec_public;

	//==========================================================
	// pipeline register
	//==========================================================

	// take a new request when empty or when the bank drains us now
	assign req_rdy  = !dec_val || dec_rdy;
	assign req_fire = req_val && req_rdy;

	// valid bit is the only control state
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			dec_val <= 1'b0;
		end else if (req_fire) begin
			dec_val <= 1'b1;
		end else if (dec_rdy) begin
			dec_val <= 1'b0;
		end
	end

	// payload loads only on acceptance
	always_ff @(posedge clk) begin
		if (req_fire) begin
			dec_type      <= req_type;
			dec_opaque    <= req_opaque;
			dec_index     <= req_index;
			dec_data      <= req_data;
			dec_err       <= req_misaligned || req_out_of_range;
			dec_sec_level <= req_level;
		end
	end

endmodule

// ==== mem_bank_exec.sv ====
// single port bank plus response register, one access per accepted request
// mem_words must be at least 2, storage is cleared by reset
`timescale 1ns/1ps

module mem_bank_exec #(
	parameter int unsigned mem_words = 64
) (
	input  logic                    clk,
	input  logic                    rst_n,

	// decoded request
	input  logic                    dec_val,
	output logic                    dec_rdy,
	input  mem_msg_pkg::msg_type_t  dec_type,
	input  mem_msg_pkg::opaque_t    dec_opaque,
	input  mem_msg_pkg::addr_t      dec_index,
	input  mem_msg_pkg::data_t      dec_data,
	input  logic                    dec_err,
	input  sec_pkg::sec_level_t     dec_sec_level,

	// response toward the access filter
	output logic                    bank_val,
	input  logic                    bank_rdy,
	output mem_msg_pkg::msg_type_t  bank_type,
	output mem_msg_pkg::opaque_t    bank_opaque,
	output mem_msg_pkg::data_t      bank_data,
	output logic                    bank_fail,
	output sec_pkg::sec_level_t     bank_sec_level
);

	import mem_msg_pkg::*;

	// address bits actually needed by the storage array
	localparam int unsigned idx_w = $clog2(mem_words);

	data_t            mem [mem_words];
	logic [idx_w-1:0] bank_idx;
	logic             dec_fire;

	// upper index bits are zero whenever dec_err is low
	assign bank_idx = dec_index[idx_w-1:0];

	// accept when the response slot is free or draining this edge
	assign dec_rdy  = !bank_val || bank_rdy;
	assign dec_fire = dec_val && dec_rdy;

	//==========================================================
	// storage
	//==========================================================

	// writes land on the accept edge, errors leave the array alone
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < mem_words; i++) begin
				mem[i] <= '0;
			end
		end else if (dec_fire && !dec_err && dec_type == mt_write) begin
			mem[bank_idx] <= dec_data;
		end
	end

	//==========================================================
	// response register
	//==========================================================

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			bank_val <= 1'b0;
		end else if (dec_fire) begin
			bank_val <= 1'b1;
		end else if (bank_rdy) begin
			bank_val <= 1'b0;
		end
	end

	// type, tag and region level ride along unchanged
	always_ff @(posedge clk) begin
		if (dec_fire) begin
			bank_type      <= dec_type;
			bank_opaque    <= dec_opaque;
			bank_sec_level <= dec_sec_level;
			bank_fail      <= dec_err;
			// read returns old contents, write ack and errors return zero
			if (!dec_err && dec_type == mt_read) begin
				bank_data <= mem[bank_idx];
			end else begin
				bank_data <= '0;
			end
		end
	end

endmodule

// ==== proc_resp_acc.sv ====
// response access filter, purely combinational, read confidentiality only
// proc_sec_level must stay stable while responses are in flight
`timescale 1ns/1ps

module proc_resp_acc (
	// response from the bank, tagged with its region level
	input  logic                    bank_val,
	output logic                    bank_rdy,
	input  mem_msg_pkg::msg_type_t  bank_type,
	input  mem_msg_pkg::opaque_t    bank_opaque,
	input  mem_msg_pkg::data_t      bank_data,
	input  logic                    bank_fail,
	input  sec_pkg::sec_level_t     bank_sec_level,

	// current level of the processor
	input  sec_pkg::sec_level_t     proc_sec_level,

	// response to the processor
	output logic                    resp_val,
	input  logic                    resp_rdy,
	output mem_msg_pkg::msg_type_t  resp_type,
	output mem_msg_pkg::opaque_t    resp_opaque,
	output mem_msg_pkg::data_t      resp_data,
	output logic                    resp_fail
);

	import sec_pkg::*;

	logic blocked;

	// with two levels, above means secure region and public processor
	assign blocked = (bank_sec_level == sec_secure) && (proc_sec_level == sec_public);

	// handshake always passes, so a blocked request still retires
	assign resp_val = bank_val;
	assign bank_rdy = resp_rdy;

	// tag and kind stay visible to the core
	assign resp_type   = bank_type;
	assign resp_opaque = bank_opaque;

	// blank the payload and hide the error status too
	// a fail bit would leak which secure words exist
	assign resp_data = blocked ? '0 : bank_data;
	assign resp_fail = blocked ? 1'b0 : bank_fail;

endmodule

// ==== secure_mem_top.sv ====
// secure data memory port, fixed latency of 2 cycles without back-pressure
// up to two requests in flight, responses stay in request order
`timescale 1ns/1ps

module secure_mem_top #(
	parameter int unsigned mem_words   = 64,
	parameter int unsigned secure_base = 32
) (
	input  logic                    clk,
	input  logic                    rst_n,

	// processor security level
	input  sec_pkg::sec_level_t     proc_sec_level,

	// request port
	input  logic                    req_val,
	output logic                    req_rdy,
	input  mem_msg_pkg::msg_type_t  req_type,
	input  mem_msg_pkg::opaque_t    req_opaque,
	input  mem_msg_pkg::addr_t      req_addr,
	input  mem_msg_pkg::data_t      req_data,

	// response port
	output logic                    resp_val,
	input  logic                    resp_rdy,
	output mem_msg_pkg::msg_type_t  resp_type,
	output mem_msg_pkg::opaque_t    resp_opaque,
	output mem_msg_pkg::data_t      resp_data,
	output logic                    resp_fail
);

	import mem_msg_pkg::*;
	import sec_pkg::*;

	//==========================================================
	// decode to bank
	//==========================================================

	logic       dec_val;
	logic       dec_rdy;
	msg_type_t  dec_type;
	opaque_t    dec_opaque;
	addr_t      dec_index;
	data_t      dec_data;
	logic       dec_err;
	sec_level_t dec_sec_level;

	//==========================================================
	// bank to filter
	//==========================================================

	logic       bank_val;
	logic       bank_rdy;
	msg_type_t  bank_type;
	opaque_t    bank_opaque;
	data_t      bank_data;
	logic       bank_fail;
	sec_level_t bank_sec_level;

	// address check and region lookup
	mem_req_decode #(
		.mem_words   (mem_words),
		.secure_base (secure_base)
	) decode_i (.*);

	// storage and response register
	mem_bank_exec #(
		.mem_words (mem_words)
	) bank_i (.*);

	// level compare against the processor
	proc_resp_acc filter_i (.*);

endmodule

// ==== secure_mem_asserts.sv ====
// concurrent checks on the top-level handshake, bound into secure_mem_top
// violation_seen stays high once any check below has failed
`timescale 1ns/1ps

module secure_mem_asserts (
	input logic                 clk,
	input logic                 rst_n,
	input logic                 req_rdy,
	input logic                 resp_val,
	input logic                 resp_rdy,
	input mem_msg_pkg::opaque_t resp_opaque,
	input mem_msg_pkg::data_t   resp_data
);

	// sticky flag for the testbench
	logic violation_seen = 1'b0;

	//==========================================================
	// reset values
	//==========================================================

	// synchronous reset empties the response register on that edge
	resp_idle_in_reset: assert property (@(posedge clk) !rst_n |=> !resp_val)
		else begin
			violation_seen = 1'b1;
			$error("resp_val not low after a reset edge");
		end

	// empty decode register means a request can be taken
	req_ready_in_reset: assert property (@(posedge clk) !rst_n |=> req_rdy)
		else begin
			violation_seen = 1'b1;
			$error("req_rdy not high after a reset edge");
		end

	//==========================================================
	// stalled response
	//==========================================================

	// val and payload held until the processor takes it
	resp_stable_in_stall: assert property (@(posedge clk) disable iff (!rst_n)
		resp_val && !resp_rdy |=> resp_val && $stable(resp_opaque) && $stable(resp_data))
		else begin
			violation_seen = 1'b1;
			$error("stalled response changed before it was taken");
		end

endmodule

bind secure_mem_top secure_mem_asserts asserts_i (.*);

// ==== tb_secure_mem.sv ====
// self-checking testbench for the secure memory port driven by fixed seed LFSR traffic
// inputs change on the falling edge and proc_sec_level moves only with nothing in flight
`timescale 1ns/1ps

module tb_secure_mem;

	import mem_msg_pkg::*;
	import sec_pkg::*;

	localparam int unsigned mem_words   = 64;
	localparam int unsigned secure_base = 32;
	// longest any single wait may run in cycles
	localparam int unsigned max_wait    = 100;
	localparam int unsigned n_random    = 3000;

	logic       clk;
	logic       rst_n;
	sec_level_t proc_sec_level;
	logic       req_val;
	logic       req_rdy;
	msg_type_t  req_type;
	opaque_t    req_opaque;
	addr_t      req_addr;
	data_t      req_data;
	logic       resp_val;
	logic       resp_rdy;
	msg_type_t  resp_type;
	opaque_t    resp_opaque;
	data_t      resp_data;
	logic       resp_fail;

	// values for the next falling edge
	logic       pend_val;
	msg_type_t  pend_type;
	opaque_t    pend_opaque;
	addr_t      pend_addr;
	data_t      pend_data;
	logic       pend_rdy;
	sec_level_t pend_level;
	opaque_t    next_tag;

	// transfers that happen on the coming rising edge
	logic       req_fired;
	logic       resp_fired;

	// reference model and expected responses in order
	data_t       model_mem [mem_words];
	msg_type_t   exp_type_q [$];
	opaque_t     exp_opaque_q [$];
	data_t       exp_data_q [$];
	logic        exp_fail_q [$];
	logic [31:0] lfsr_state;

	secure_mem_top #(.mem_words(mem_words), .secure_base(secure_base)) dut_i (.*);

	always #50 clk = ~clk;

	//==========================================================
	// random numbers and error exits
	//==========================================================

	// taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// n fresh bits with one LFSR step each
	function automatic logic [31:0] rand_bits(input int unsigned n);
		logic [31:0] value;
		value = '0;
		for (int unsigned i = 0; i < n; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			value = {value[30:0], lfsr_state[0]};
		end
		return value;
	endfunction

	task automatic abort_run();
		$display("** FAIL **");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic report_timeout(input string what);
		$display("timed out after %0d cycles waiting for %s", max_wait, what);
		abort_run();
	endtask

	//==========================================================
	// compare tasks
	//==========================================================

	task automatic check_type(input string name, input msg_type_t got, input msg_type_t exp);
		if (got !== exp) begin
			$display("[FAIL] t=%0t %s got %0d expected %0d", $time, name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_opaque(input string name, input opaque_t got, input opaque_t exp);
		if (got !== exp) begin
			$display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_data(input string name, input data_t got, input data_t exp);
		if (got !== exp) begin
			$display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_fail(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("[FAIL] t=%0t %s got %b expected %b", $time, name, got, exp);
			abort_run();
		end
	endtask

	// handshake levels
	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("[FAIL] t=%0t %s got %b expected %b", $time, name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_cycles(input string name, input int unsigned got, input int unsigned exp);
		if (got != exp) begin
			$display("[FAIL] t=%0t %s got %0d expected %0d", $time, name, got, exp);
			abort_run();
		end
	endtask

	//==========================================================
	// model and cycle driver
	//==========================================================

	// decode, bank and filter rules applied in request order
	task automatic model_request();
		addr_t      index;
		logic       err;
		sec_level_t level;
		data_t      data;
		logic       fail;
		index = req_addr >> 2;
		err   = (req_addr[1:0] != 2'b00) || (index >= mem_words);
		level = (index >= secure_base) ? sec_secure : sec_public;
		data  = '0;
		fail  = err;
		if (!err && req_type == mt_read) data = model_mem[index];
		if (!err && req_type == mt_write) model_mem[index] = req_data;
		// region above the processor level is blanked
		if (level > proc_sec_level) begin
			data = '0;
			fail = 1'b0;
		end
		exp_type_q.push_back(req_type);
		exp_opaque_q.push_back(req_opaque);
		exp_data_q.push_back(data);
		exp_fail_q.push_back(fail);
	endtask

	task automatic check_response();
		if (exp_type_q.size() == 0) begin
			$display("a response arrived at %0t with no request outstanding", $time);
			abort_run();
		end else begin
			check_type("resp_type", resp_type, exp_type_q.pop_front());
			check_opaque("resp_opaque", resp_opaque, exp_opaque_q.pop_front());
			check_data("resp_data", resp_data, exp_data_q.pop_front());
			check_fail("resp_fail", resp_fail, exp_fail_q.pop_front());
		end
	endtask

	// drive on the falling edge and sample once everything has settled
	task automatic step_cycle();
		@(negedge clk);
		req_val        = pend_val;
		req_type       = pend_type;
		req_opaque     = pend_opaque;
		req_addr       = pend_addr;
		req_data       = pend_data;
		resp_rdy       = pend_rdy;
		proc_sec_level = pend_level;
		#10;
		req_fired  = req_val && req_rdy;
		resp_fired = resp_val && resp_rdy;
		if (dut_i.asserts_i.violation_seen) begin
			$display("a bound assertion on the DUT failed before %0t", $time);
			abort_run();
		end else begin
			if (resp_fired) check_response();
			if (req_fired) model_request();
		end
	endtask

	// hold one request until it is taken
	task automatic send_request(input msg_type_t kind, input addr_t addr, input data_t data);
		int unsigned waited;
		pend_val    = 1'b1;
		pend_type   = kind;
		pend_opaque = next_tag;
		pend_addr   = addr;
		pend_data   = data;
		next_tag    = next_tag + 1'b1;
		waited      = 0;
		step_cycle();
		while (!req_fired) begin
			if (waited > max_wait) begin
				report_timeout("req_rdy on a directed request");
			end else begin
				step_cycle();
				waited++;
			end
		end
		pend_val = 1'b0;
	endtask

	task automatic drain_responses();
		int unsigned waited;
		pend_val = 1'b0;
		pend_rdy = 1'b1;
		waited   = 0;
		while (exp_type_q.size() != 0) begin
			if (waited > max_wait) begin
				report_timeout("outstanding responses to drain");
			end else begin
				step_cycle();
				waited++;
			end
		end
	endtask

	// single request into an empty pipeline with resp_rdy high
	task automatic check_latency();
		int unsigned waited;
		pend_rdy = 1'b1;
		send_request(mt_write, addr_t'(4 * 3), 32'h1234_5678);
		waited = 0;
		while (!resp_fired) begin
			if (waited > max_wait) begin
				report_timeout("resp_val after a single request");
			end else begin
				step_cycle();
				waited++;
			end
		end
		check_cycles("response latency", waited, 2);
	endtask

	//==========================================================
	// random traffic
	//==========================================================

	task automatic make_random_request();
		addr_t index;
		addr_t offset;
		// both regions plus a few words past the end
		index  = addr_t'(rand_bits(7) % (mem_words + 8));
		offset = '0;
		// about one request in eleven gets a misaligned offset
		if (rand_bits(3) == 0) offset = addr_t'(rand_bits(2));
		pend_val    = 1'b1;
		pend_type   = msg_type_t'(rand_bits(1));
		pend_opaque = next_tag;
		pend_addr   = (index << 2) | offset;
		pend_data   = data_t'(rand_bits(32));
		next_tag    = next_tag + 1'b1;
	endtask

	task automatic random_traffic();
		int unsigned n;
		int unsigned waited;
		n      = 0;
		waited = 0;
		while (n < n_random || pend_val) begin
			if (exp_type_q.size() == 0 && rand_bits(3) == 0) begin
				pend_level = sec_level_t'(rand_bits(1));
			end
			if (!pend_val && n < n_random && rand_bits(2) != 0) make_random_request();
			pend_rdy = (rand_bits(2) != 0);
			if (waited > max_wait) begin
				report_timeout("req_rdy during random traffic");
			end else begin
				step_cycle();
			end
			n++;
			if (req_fired) begin
				pend_val = 1'b0;
				waited   = 0;
			end else if (pend_val) begin
				waited++;
			end
		end
	endtask

	//==========================================================
	// main sequence
	//==========================================================

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		proc_sec_level = sec_public;
		req_val = 1'b0;
		req_type = mt_read;
		req_opaque = '0;
		req_addr = '0;
		req_data = '0;
		resp_rdy = 1'b0;
		pend_val = 1'b0;
		pend_type = mt_read;
		pend_opaque = '0;
		pend_addr = '0;
		pend_data = '0;
		pend_rdy = 1'b0;
		pend_level = sec_public;
		next_tag = '0;
		req_fired = 1'b0;
		resp_fired = 1'b0;
		lfsr_state = 32'ha788_03b7;
		// bank storage comes out of reset as zero
		for (int i = 0; i < mem_words; i++) begin
			model_mem[i] = '0;
		end
		repeat (16) @(negedge clk);
		rst_n = 1'b1;

		// idle after reset then fixed latency
		pend_rdy = 1'b1;
		step_cycle();
		check_flag("resp_val", resp_val, 1'b0);
		check_flag("req_rdy", req_rdy, 1'b1);
		check_latency();

		// write ack and read back of a public word at both levels
		send_request(mt_write, addr_t'(4 * 5), 32'hcafe_0005);
		send_request(mt_read, addr_t'(4 * 5), '0);
		drain_responses();
		pend_level = sec_secure;
		send_request(mt_write, addr_t'(4 * 6), 32'hbeef_0006);
		send_request(mt_read, addr_t'(4 * 6), '0);
		send_request(mt_read, addr_t'(4 * 5), '0);

		// secure word readable only at the secure level
		send_request(mt_write, addr_t'(4 * 40), 32'h5ec0_0040);
		send_request(mt_read, addr_t'(4 * 40), '0);
		// misaligned write and out of range read both fail
		send_request(mt_write, addr_t'(4 * 5 + 1), 32'hdead_0005);
		send_request(mt_read, addr_t'(4 * mem_words), '0);
		send_request(mt_read, addr_t'(4 * 5), '0);
		drain_responses();
		pend_level = sec_public;
		send_request(mt_read, addr_t'(4 * 40), '0);
		// fail hidden for a secure misaligned address
		send_request(mt_read, addr_t'(4 * 40 + 2), '0);
		drain_responses();

		random_traffic();
		drain_responses();

		if (exp_type_q.size() != 0) begin
			$display("%0d expected responses never arrived", exp_type_q.size());
			abort_run();
		end else begin
			$display("** PASS **");
			$finish;
		end
	end

endmodule

// ==== all.f ====
mem_msg_pkg.sv
sec_pkg.sv
mem_req_decode.sv
mem_bank_exec.sv
proc_resp_acc.sv
secure_mem_top.sv
secure_mem_asserts.sv
tb_secure_mem.sv

// ==== Bender.yml ====
package:
  name: secure_mem

sources:
  # packages first, then the design in bottom-up order
  - mem_msg_pkg.sv
  - sec_pkg.sv
  - mem_req_decode.sv
  - mem_bank_exec.sv
  - proc_resp_acc.sv
  - secure_mem_top.sv
  # testbench with bound assertions, top module tb_secure_mem
  - target: test
    files:
      - secure_mem_asserts.sv
      - tb_secure_mem.sv
